/* verilog/dll_pkg.sv */
package dll_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths with a meaning of their own.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// control word of the delay line, 0 is the shortest delay.
	typedef logic [4:0] delay_code_t;

	// the loop filter integrates votes in two's complement.
	typedef logic signed [3:0] filt_acc_t;

	// settled sample count and vote run length.
	typedef logic [4:0] lock_cnt_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grouped signals.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one comparison of the phase detector.
	typedef struct packed {
		logic up;
		logic dn;
	} pd_sample_t;

	// step request towards the code register, never both bits.
	typedef struct packed {
		logic inc;
		logic dec;
	} step_t;

	// configuration transaction sent to the delay line.
	typedef struct packed {
		delay_code_t delay_code;
		logic        locked;
		logic        at_limit;
	} dll_cfg_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// loop constants.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam filt_acc_t   FILT_LIMIT = 4'sd4;
	localparam lock_cnt_t   LOCK_COUNT = 5'd16;
	localparam lock_cnt_t   MAX_RUN    = 5'd2;
	localparam delay_code_t CODE_RESET = 5'd16;

endpackage

/* verilog/dll_loop_filter.sv */
module dll_loop_filter
(
	input  logic                i_clkp,
	input  logic                i_dll_en,
	input  logic                i_take,
	input  dll_pkg::pd_sample_t i_pd,
	input  logic                i_stage_ready,
	output logic                o_stage_valid,
	output dll_pkg::step_t      o_step,
	output logic                o_take_ok
);

	import dll_pkg::*;

	logic      vote_up;
	logic      vote_dn;
	filt_acc_t acc_q;
	filt_acc_t acc_sum;
	filt_acc_t acc_next;
	step_t     step_next;
	step_t     step_q;
	logic      stage_valid_q;

	// a vote counts only when exactly one of the two bits is set.
	assign vote_up = i_pd.up & ~i_pd.dn;
	assign vote_dn = i_pd.dn & ~i_pd.up;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// integrator.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		acc_sum = acc_q;
		if (vote_up)
		begin
			acc_sum = acc_q + 4'sd1;
		end
		else if (vote_dn)
		begin
			acc_sum = acc_q - 4'sd1;
		end
	end

	// reaching either limit emits one step and restarts the integration.
	always_comb
	begin
		acc_next = acc_sum;
		step_next = '0;
		if (acc_sum == FILT_LIMIT)
		begin
			acc_next = '0;
			step_next.inc = 1'b1;
		end
		else if (acc_sum == -FILT_LIMIT)
		begin
			acc_next = '0;
			step_next.dec = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the stage can take a sample when it is empty or being drained.
	assign o_take_ok = ~stage_valid_q | i_stage_ready;

	always_ff @(posedge i_clkp or negedge i_dll_en)
	begin
		if (!i_dll_en)
		begin
			acc_q <= '0;
			step_q <= '0;
			stage_valid_q <= 1'b0;
		end
		else if (i_take)
		begin
			acc_q <= acc_next;
			step_q <= step_next;
			stage_valid_q <= 1'b1;
		end
		else if (i_stage_ready)
		begin
			stage_valid_q <= 1'b0;
		end
	end

	assign o_stage_valid = stage_valid_q;
	assign o_step = step_q;

endmodule

/* verilog/dll_lock_detect.sv */
module dll_lock_detect
(
	input  logic                i_clkp,
	input  logic                i_dll_en,
	input  logic                i_take,
	input  dll_pkg::pd_sample_t i_pd,
	output logic                o_locked
);

	import dll_pkg::*;

	logic      vote_up;
	logic      vote_dn;
	logic      last_up_q;
	logic      last_up_next;
	lock_cnt_t run_q;
	lock_cnt_t run_next;
	logic      run_over;
	lock_cnt_t settled_q;
	lock_cnt_t settled_next;
	logic      locked_q;
	logic      locked_next;

	assign vote_up = i_pd.up & ~i_pd.dn;
	assign vote_dn = i_pd.dn & ~i_pd.up;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// run length of the last vote direction.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a zero run after reset makes the first vote start a run of one
	// whatever its direction.
	always_comb
	begin
		run_next = run_q;
		last_up_next = last_up_q;
		if (vote_up || vote_dn)
		begin
			if (vote_up != last_up_q)
			begin
				run_next = 5'd1;
				last_up_next = vote_up;
			end
			else if (run_q <= MAX_RUN)
			begin
				run_next = run_q + 5'd1;
			end
		end
	end

	assign run_over = run_next > MAX_RUN;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// settled counter and lock decision.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		settled_next = settled_q;
		locked_next = locked_q;
		if (run_over)
		begin
			settled_next = '0;
			locked_next = 1'b0;
		end
		else
		begin
			if (settled_q != LOCK_COUNT)
			begin
				settled_next = settled_q + 5'd1;
			end
			locked_next = settled_next == LOCK_COUNT;
		end
	end

	// updates follow the input transfer, so the bit lines up with the filter step.
	always_ff @(posedge i_clkp or negedge i_dll_en)
	begin
		if (!i_dll_en)
		begin
			last_up_q <= 1'b0;
			run_q <= '0;
			settled_q <= '0;
			locked_q <= 1'b0;
		end
		else if (i_take)
		begin
			last_up_q <= last_up_next;
			run_q <= run_next;
			settled_q <= settled_next;
			locked_q <= locked_next;
		end
	end

	assign o_locked = locked_q;

endmodule

/* verilog/dll_code_ctrl.sv */
module dll_code_ctrl
(
	input  logic              i_clkp,
	input  logic              i_dll_en,
	input  logic              i_stage_valid,
	input  dll_pkg::step_t    i_step,
	input  logic              i_locked,
	output logic              o_stage_ready,
	output logic              o_cfg_valid,
	output dll_pkg::dll_cfg_t o_cfg,
	input  logic              i_cfg_ready
);

	import dll_pkg::*;

	delay_code_t code_q;
	delay_code_t code_next;
	logic        locked_q;
	logic        at_top;
	logic        at_bottom;
	logic        blocked;
	logic        report;
	logic        consume;
	logic        cfg_valid_q;
	dll_cfg_t    cfg_q;
	dll_cfg_t    cfg_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// saturating code update.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign at_top = code_q == delay_code_t'('1);
	assign at_bottom = code_q == '0;

	always_comb
	begin
		code_next = code_q;
		blocked = 1'b0;
		if (i_step.inc)
		begin
			if (at_top)
			begin
				blocked = 1'b1;
			end
			else
			begin
				code_next = code_q + 5'd1;
			end
		end
		else if (i_step.dec)
		begin
			if (at_bottom)
			begin
				blocked = 1'b1;
			end
			else
			begin
				code_next = code_q - 5'd1;
			end
		end
	end

	// a sample that changes nothing is consumed without a transaction.
	assign report = (code_next != code_q) | (i_locked != locked_q) | blocked;

	always_comb
	begin
		cfg_next.delay_code = code_next;
		cfg_next.locked = i_locked;
		cfg_next.at_limit = blocked;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register and handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign o_stage_ready = ~cfg_valid_q | i_cfg_ready;
	assign consume = i_stage_valid & o_stage_ready;

	always_ff @(posedge i_clkp or negedge i_dll_en)
	begin
		if (!i_dll_en)
		begin
			code_q <= CODE_RESET;
			locked_q <= 1'b0;
			cfg_valid_q <= 1'b0;
		end
		else
		begin
			if (consume)
			begin
				code_q <= code_next;
				locked_q <= i_locked;
			end
			if (consume && report)
			begin
				cfg_valid_q <= 1'b1;
			end
			else if (i_cfg_ready)
			begin
				cfg_valid_q <= 1'b0;
			end
		end
	end

	// the word only loads when a new transaction replaces a taken one.
	always_ff @(posedge i_clkp)
	begin
		if (consume && report)
		begin
			cfg_q <= cfg_next;
		end
	end

	assign o_cfg_valid = cfg_valid_q;
	assign o_cfg = cfg_q;

endmodule

/* verilog/dll_ctrl_top.sv */
module dll_ctrl_top
(
	input  logic                i_clkp,
	input  logic                i_dll_en,
	input  logic                i_pd_valid,
	input  dll_pkg::pd_sample_t i_pd,
	output logic                o_pd_ready,
	output logic                o_cfg_valid,
	output dll_pkg::dll_cfg_t   o_cfg,
	input  logic                i_cfg_ready
);

	import dll_pkg::*;

	logic  take_ok;
	logic  take;
	logic  stage_valid;
	logic  stage_ready;
	step_t step;
	logic  locked;

	// one transfer drives both blocks, so their results share a stage.
	assign take = i_pd_valid & take_ok;
	assign o_pd_ready = take_ok;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// vote processing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	dll_loop_filter dll_loop_filter_i
	(
		.i_clkp        (i_clkp),
		.i_dll_en      (i_dll_en),
		.i_take        (take),
		.i_pd          (i_pd),
		.i_stage_ready (stage_ready),
		.o_stage_valid (stage_valid),
		.o_step        (step),
		.o_take_ok     (take_ok)
	);

	// stage valid comes from the filter alone.
	dll_lock_detect dll_lock_detect_i
	(
		.i_clkp   (i_clkp),
		.i_dll_en (i_dll_en),
		.i_take   (take),
		.i_pd     (i_pd),
		.o_locked (locked)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// code register and configuration output.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	dll_code_ctrl dll_code_ctrl_i
	(
		.i_clkp        (i_clkp),
		.i_dll_en      (i_dll_en),
		.i_stage_valid (stage_valid),
		.i_step        (step),
		.i_locked      (locked),
		.o_stage_ready (stage_ready),
		.o_cfg_valid   (o_cfg_valid),
		.o_cfg         (o_cfg),
		.i_cfg_ready   (i_cfg_ready)
	);

endmodule

/* tests/dll_ctrl_chk.sv */
module dll_ctrl_chk
(
	input logic              i_clkp,
	input logic              i_dll_en,
	input dll_pkg::step_t    i_step,
	input logic              o_cfg_valid,
	input dll_pkg::dll_cfg_t o_cfg,
	input logic              i_cfg_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// a transaction that waits for the sink keeps both valid and its word.
	cfg_hold: assert property (@(posedge i_clkp) disable iff (!i_dll_en)
		o_cfg_valid && !i_cfg_ready |=> o_cfg_valid && $stable(o_cfg))
		else $error("o_cfg changed or valid dropped while the sink was not ready");

	cfg_reset: assert property (@(posedge i_clkp) !i_dll_en |-> !o_cfg_valid)
		else $error("o_cfg_valid was high while i_dll_en held the block in reset");

	// the filter never asks for both directions at once.
	step_onehot: assert property (@(posedge i_clkp) disable iff (!i_dll_en)
		!(i_step.inc && i_step.dec))
		else $error("step request had inc and dec set together");

endmodule

bind dll_code_ctrl dll_ctrl_chk dll_ctrl_chk_i
(
	.i_clkp      (i_clkp),
	.i_dll_en    (i_dll_en),
	.i_step      (i_step),
	.o_cfg_valid (o_cfg_valid),
	.o_cfg       (o_cfg),
	.i_cfg_ready (i_cfg_ready)
);

/* tests/dll_ctrl_tb.sv */
module dll_ctrl_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import dll_pkg::*;

	logic       i_clkp;
	logic       i_dll_en;
	logic       i_pd_valid;
	pd_sample_t i_pd;
	logic       o_pd_ready;
	logic       o_cfg_valid;
	dll_cfg_t   o_cfg;
	logic       i_cfg_ready;

	int       valid_pct;
	int       ready_pct;
	int       wait_limit;
	bit       alt_up;
	dll_cfg_t last_cfg;
	dll_cfg_t exp_q[$];

	// reference model state.
	int m_acc;
	int m_code;
	bit m_locked;
	bit m_last_up;
	int m_run;
	int m_settled;

	dll_ctrl_top dll_ctrl_top_i
	(
		.i_clkp      (i_clkp),
		.i_dll_en    (i_dll_en),
		.i_pd_valid  (i_pd_valid),
		.i_pd        (i_pd),
		.o_pd_ready  (o_pd_ready),
		.o_cfg_valid (o_cfg_valid),
		.o_cfg       (o_cfg),
		.i_cfg_ready (i_cfg_ready)
	);

	initial
	begin
		i_clkp = 1'b0;
		forever #4 i_clkp = ~i_clkp;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// error reporting and compares.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	task automatic report_fault(input string msg);
		$display("%s (at %0t ns)", msg, $time);
		stop_run();
	endtask

	task automatic check_cfg(input dll_cfg_t got, input dll_cfg_t exp);
		if (got !== exp)
		begin
			report_mismatch($sformatf("cfg code %0d locked %b limit %b, expected %0d %b %b",
				got.delay_code, got.locked, got.at_limit,
				exp.delay_code, exp.locked, exp.at_limit));
		end
	endtask

	task automatic check_ready_idle(input logic cfg_valid, input logic pd_ready);
		if (cfg_valid !== 1'b0 || pd_ready !== 1'b1)
		begin
			report_mismatch($sformatf("idle o_cfg_valid %b o_pd_ready %b, expected 0 1",
				cfg_valid, pd_ready));
		end
	endtask

	function automatic dll_cfg_t make_cfg(input int code, input bit locked, input bit limit);
		dll_cfg_t c;
		c.delay_code = delay_code_t'(code);
		c.locked = locked;
		c.at_limit = limit;
		return c;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model, one call per accepted sample.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic model_sample(input pd_sample_t s);
		bit up;
		bit dn;
		bit lock_now;
		bit blocked;
		int step;
		int code_new;
		up = s.up && !s.dn;
		dn = s.dn && !s.up;
		step = 0;
		if (up)
			m_acc++;
		else if (dn)
			m_acc--;
		if (m_acc == int'(FILT_LIMIT))
		begin
			step = 1;
			m_acc = 0;
		end
		else if (m_acc == -int'(FILT_LIMIT))
		begin
			step = -1;
			m_acc = 0;
		end
		// a vote in the other direction, or the first vote, starts a new run.
		if (up || dn)
		begin
			if (m_run > 0 && up == m_last_up)
				m_run++;
			else
			begin
				m_run = 1;
				m_last_up = up;
			end
		end
		if (m_run > int'(MAX_RUN))
		begin
			m_settled = 0;
			lock_now = 1'b0;
		end
		else
		begin
			if (m_settled < int'(LOCK_COUNT))
				m_settled++;
			lock_now = m_settled == int'(LOCK_COUNT);
		end
		blocked = (step == 1 && m_code == 31) || (step == -1 && m_code == 0);
		code_new = blocked ? m_code : m_code + step;
		if (code_new != m_code || lock_now != m_locked || blocked)
			exp_q.push_back(make_cfg(code_new, lock_now, blocked));
		m_code = code_new;
		m_locked = lock_now;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and sink.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// blocks of up-heavy, down-heavy and mostly alternating votes.
	function automatic pd_sample_t random_sample(input int index);
		pd_sample_t s;
		int r;
		int phase;
		r = $urandom_range(99);
		phase = (index / 250) % 3;
		if (r < 10)
		begin
			s.up = r[0];
			s.dn = r[0];
		end
		else if (phase < 2)
		begin
			s.up = (phase == 0) ? (r < 65) : (r < 40);
			s.dn = !s.up;
		end
		else
		begin
			if (r >= 15)
				alt_up = !alt_up;
			s.up = alt_up;
			s.dn = !alt_up;
		end
		return s;
	endfunction

	task automatic send_sample(input pd_sample_t s);
		int gap;
		int waited;
		gap = 0;
		waited = 0;
		@(negedge i_clkp);
		while (gap < 8 && $urandom_range(99) >= valid_pct)
		begin
			i_pd_valid = 1'b0;
			gap++;
			@(negedge i_clkp);
		end
		i_pd_valid = 1'b1;
		i_pd = s;
		#1;
		while (!o_pd_ready)
		begin
			waited++;
			if (waited > wait_limit)
				report_fault("timeout: o_pd_ready stayed low with a sample waiting");
			@(negedge i_clkp);
			#1;
		end
		// the transfer happens on the coming rising edge.
		model_sample(s);
	endtask

	task automatic send_run(input bit up, input bit dn, input int count);
		pd_sample_t s;
		s.up = up;
		s.dn = dn;
		repeat (count) send_sample(s);
	endtask

	task automatic wait_drain();
		int waited;
		int quiet;
		waited = 0;
		quiet = 0;
		@(negedge i_clkp);
		i_pd_valid = 1'b0;
		// two quiet cycles in a row mean the stage has emptied as well.
		while (quiet < 2)
		begin
			@(negedge i_clkp);
			#2;
			if (exp_q.size() == 0 && !o_cfg_valid)
				quiet++;
			else
				quiet = 0;
			waited++;
			if (waited > wait_limit)
				report_fault("timeout: expected transactions never left the DUT");
		end
	endtask

	task automatic take_cfg();
		last_cfg = o_cfg;
		if (exp_q.size() == 0)
			report_fault("the DUT sent a transaction that the model did not expect");
		else
			check_cfg(o_cfg, exp_q.pop_front());
	endtask

	initial
	begin
		i_cfg_ready = 1'b0;
		forever
		begin
			@(negedge i_clkp);
			i_cfg_ready = $urandom_range(99) < ready_pct;
			#1;
			if (i_dll_en && o_cfg_valid && i_cfg_ready)
				take_cfg();
		end
	end

	initial
	begin
		int i;
		void'($urandom(32'hd37b_7f44));
		i_dll_en = 1'b0;
		i_pd_valid = 1'b0;
		i_pd = '0;
		valid_pct = 100;
		ready_pct = 100;
		wait_limit = 2000;
		alt_up = 1'b0;
		m_acc = 0;
		m_code = int'(CODE_RESET);
		m_locked = 1'b0;
		m_last_up = 1'b0;
		m_run = 0;
		m_settled = 0;
		repeat (10) @(negedge i_clkp);
		i_dll_en = 1'b1;
		#1;
		check_ready_idle(o_cfg_valid, o_pd_ready);

		// four up votes make the first step away from the reset code.
		send_run(1'b1, 1'b0, int'(FILT_LIMIT));
		wait_drain();
		check_cfg(last_cfg, make_cfg(int'(CODE_RESET) + 1, 1'b0, 1'b0));
		send_run(1'b0, 1'b1, 2 * int'(FILT_LIMIT));
		wait_drain();
		check_cfg(last_cfg, make_cfg(int'(CODE_RESET) - 1, 1'b0, 1'b0));
		for (i = 0; i < 10; i++)
			send_run(i[0], i[0], 1);
		wait_drain();

		// run into both ends of the code range.
		send_run(1'b1, 1'b0, 4 * 19);
		wait_drain();
		check_cfg(last_cfg, make_cfg(31, 1'b0, 1'b1));
		send_run(1'b0, 1'b1, 4 * 34);
		wait_drain();
		check_cfg(last_cfg, make_cfg(0, 1'b0, 1'b1));

		for (i = 0; i < int'(LOCK_COUNT); i++)
			send_run(!i[0], i[0], 1);
		wait_drain();
		check_cfg(last_cfg, make_cfg(0, 1'b1, 1'b0));
		send_run(1'b1, 1'b0, 3);
		wait_drain();
		check_cfg(last_cfg, make_cfg(0, 1'b0, 1'b0));

		valid_pct = 80;
		ready_pct = 30;
		for (i = 0; i < 600; i++)
			send_sample(random_sample(i));
		wait_drain();

		valid_pct = 70;
		ready_pct = 70;
		for (i = 0; i < 5000; i++)
			send_sample(random_sample(i));
		wait_drain();
		check_ready_idle(o_cfg_valid, o_pd_ready);

		$display("** PASS **");
		$finish;
	end

endmodule

/* sources.f */
verilog/dll_pkg.sv
verilog/dll_loop_filter.sv
verilog/dll_lock_detect.sv
verilog/dll_code_ctrl.sv
verilog/dll_ctrl_top.sv
tests/dll_ctrl_chk.sv
tests/dll_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= dll_ctrl_tb
RTL_TOP   ?= dll_ctrl_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  := ** PASS **
FAIL_MSG  := ** FAIL **
RTL_FILES := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not pass"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
